// File: common/mmuPkg.sv
package mmuPkg;

    ////////////////////////////////////////////////////////////////////
    // Translation port structs
    ////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic        valid;
        logic [19:0] vpn;
    } TransReq;

    typedef struct packed {
        logic        hit;
        logic        fault;
        logic [19:0] ppn;  // Low 10 bits from vpn on superpage.
    } TransRes;

    typedef struct packed {
        logic        valid;
        logic [19:0] vpn;
    } MissReq;

    ////////////////////////////////////////////////////////////////////
    // Page walk structs
    ////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic        valid;
        logic [19:0] vpn;
        logic [21:0] ppn;       // Full Sv32 ppn.
        logic        isSuper;
        logic [2:0]  rwx;       // {r, w, x}.
        logic        pageFault;
    } WalkRes;

    // Sv32 page table entry as it sits in memory.
    typedef struct packed {
        logic [21:0] ppn;
        logic [1:0]  rsvd;
        logic        dirty;
        logic        accessed;
        logic        isGlobal;
        logic        user;
        logic        x;
        logic        w;
        logic        r;
        logic        v;
    } Pte;

    typedef enum logic [2:0] {
        Idle,
        ReqL1,
        WaitL1,
        ReqL0,
        WaitL0,
        Done
    } WalkState;

endpackage

// File: dv/mmuTb.sv
`timescale 1ns/1ps

module mmuTb;

    localparam logic [21:0] RootPpn = 22'd1;
    localparam int Page4k = 0;
    localparam int Super = 1;
    localparam int Misalign = 2;
    localparam int NoWrite = 3;
    localparam int L0Fault = 4;
    localparam int HighPpn = 5;

    typedef struct packed {
        logic        walkFault;
        logic        misaligned;
        logic        twoLevel;
        logic        cacheable;
        logic        isSuper;
        logic [21:0] ppn;
        logic        r;
        logic        w;
        logic        x;
    } Expect;

    logic            clk;
    logic            reset;
    logic            clear;
    mmuPkg::TransReq rqs [2];
    mmuPkg::TransRes res [2];
    logic            memReq;
    logic [33:0]     memAddr;
    logic            memValid;
    logic [31:0]     memData;
    mmuPkg::WalkRes  walkOut;

    int seed = 32'h55b15814;
    int errors;
    int testErrors;
    int testNum;
    int memReads;
    int walkCount [int];
    bit seenHit [int];
    bit seenWalk [int];

    always #2 clk = !clk;

    mmuTop #(.TlbSize(8), .TlbAssoc(4), .QueueDepth(4)) i_dut (
        .clk(clk), .reset(reset), .clear(clear), .rqs(rqs), .res(res), .rootPpn(RootPpn),
        .memReq(memReq), .memAddr(memAddr), .memValid(memValid), .memData(memData),
        .walkOut(walkOut)
    );

    pageTableMem #(.Seed(32'h55b15814)) i_mem (
        .clk(clk), .reset(reset), .memReq(memReq), .memAddr(memAddr),
        .memValid(memValid), .memData(memData)
    );

    ////////////////////////////////////////////////////////////////////
    // Reference walk over the table memory
    ////////////////////////////////////////////////////////////////////

    function automatic Expect model(logic [19:0] vpn);
        mmuPkg::Pte pte;
        Expect      e;
        e   = '0;
        pte = mmuPkg::Pte'(i_mem.words[{RootPpn[1:0], vpn[19:10]}]);
        if (!pte.v || (pte.w && !pte.r)) begin
            e.walkFault = 1'b1;
        end else if (pte.r || pte.w || pte.x) begin
            e.isSuper    = 1'b1;
            e.misaligned = pte.ppn[9:0] != 10'd0;
            e.walkFault  = e.misaligned;
        end else begin
            e.twoLevel  = 1'b1;
            pte         = mmuPkg::Pte'(i_mem.words[{pte.ppn[1:0], vpn[9:0]}]);
            e.walkFault = !pte.v || (pte.w && !pte.r) || !(pte.r || pte.w || pte.x);
        end
        e.ppn       = pte.ppn;
        e.r         = pte.r;
        e.w         = pte.w;
        e.x         = pte.x;
        e.cacheable = !e.walkFault && e.ppn[21:20] == 2'b00 && (e.r || e.w);  // Only w, r kept.
        return e;
    endfunction

    // Watches every hit, every walk and every memory read.
    always @(negedge clk) begin
        Expect       e;
        logic [19:0] ppn;
        logic [25:0] got;
        if (!reset) begin
            for (int p = 0; p < 2; p++) begin
                if (rqs[p].valid && res[p].hit) begin
                    e   = model(rqs[p].vpn);
                    ppn = e.isSuper ? {e.ppn[19:10], rqs[p].vpn[9:0]} : e.ppn[19:0];
                    seenHit[rqs[p].vpn] = 1'b1;
                    if (!e.cacheable || res[p].ppn != ppn
                        || res[p].fault != ((p == 0) ? !e.w : !e.r)) begin
                        $display("ERROR %0t: port %0d vpn %h hit %h fault %b, expected %h %b%s",
                                 $time, p, rqs[p].vpn, res[p].ppn, res[p].fault, ppn,
                                 (p == 0) ? !e.w : !e.r, e.cacheable ? "" : " and no hit");
                        errors++;
                    end
                end
            end
            if (memReq) begin
                memReads++;
                if (memAddr[33:14] != '0) begin
                    $display("Memory read at %h lies outside the page tables", memAddr);
                    errors++;
                end
            end
            if (walkOut.valid) begin
                e = model(walkOut.vpn);
                seenWalk[walkOut.vpn]  = 1'b1;
                walkCount[walkOut.vpn] = walkCount.exists(walkOut.vpn)
                                         ? walkCount[walkOut.vpn] + 1 : 1;
                got = {walkOut.ppn, walkOut.isSuper, walkOut.rwx};
                if (walkOut.pageFault != e.walkFault
                    || (!e.walkFault && got != {e.ppn, e.isSuper, e.r, e.w, e.x})) begin
                    $display("ERROR %0t: walk of vpn %h gave fault %b ppn %h, expected %b %h",
                             $time, walkOut.vpn, walkOut.pageFault, walkOut.ppn, e.walkFault,
                             e.ppn);
                    errors++;
                end
                if (memReads < 1 || memReads > 2) begin
                    $display("Walk of vpn %h used %0d memory reads", walkOut.vpn, memReads);
                    errors++;
                end
                memReads = 0;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////////////////////////////////

    task automatic findVpn(input int kind, output logic [19:0] vpn);
        Expect e;
        bit    found;
        found = 1'b0;
        for (int t = 0; t < 100000 && !found; t++) begin
            vpn = 20'($random(seed));
            e   = model(vpn);
            case (kind)
                Page4k: found = e.cacheable && !e.isSuper && e.w;
                Super: found = e.cacheable && e.isSuper;
                Misalign: found = e.misaligned;
                NoWrite: found = e.cacheable && !e.w;
                L0Fault: found = e.walkFault && e.twoLevel;
                default: found = !e.walkFault && e.ppn[21:20] != 2'b00;
            endcase
        end
        if (!found) begin
            $display("The page tables hold no page of kind %0d", kind);
            errors++;
        end
    endtask

    task automatic waitIdle();
        int quiet;
        int cycle;
        quiet = 0;
        cycle = 0;
        while (quiet < 12 && cycle < 500) begin
            @(posedge clk);
            #1;
            quiet = (memReq || walkOut.valid) ? 0 : quiet + 1;
            cycle++;
        end
        if (quiet < 12) begin
            $display("Timeout: the page walker did not go idle");
            errors++;
        end
    endtask

    // Rotates unresolved pages over both ports until each hit or walked uncached.
    task automatic runSet(input logic [19:0] vpns [$], input int limit);
        logic [19:0] pending [$];
        Expect       e;
        int          cycle;
        foreach (vpns[i]) begin
            seenHit.delete(vpns[i]);
            seenWalk.delete(vpns[i]);
            walkCount.delete(vpns[i]);
        end
        pending = vpns;
        cycle   = 0;
        while (pending.size() > 0 && cycle < limit) begin
            rqs[0].valid = 1'b1;
            rqs[0].vpn   = pending[cycle % pending.size()];
            rqs[1].valid = 1'b1;
            rqs[1].vpn   = pending[(cycle + 1) % pending.size()];
            @(posedge clk);
            #1;
            cycle++;
            for (int i = pending.size() - 1; i >= 0; i--) begin
                e = model(pending[i]);
                if (seenHit.exists(pending[i])
                    || (seenWalk.exists(pending[i]) && !e.cacheable)) begin
                    pending.delete(i);
                end
            end
        end
        rqs[0].valid = 1'b0;
        rqs[1].valid = 1'b0;
        if (pending.size() > 0) begin
            $display("Timeout: %0d pages unresolved after %0d cycles", pending.size(), cycle);
            errors++;
        end
        waitIdle();
    endtask

    // Presents one page on both ports for a cycle and checks the hit flags.
    task automatic probeHit(input logic [19:0] vpn, input bit expectHit);
        rqs[0].valid = 1'b1;
        rqs[0].vpn   = vpn;
        rqs[1]       = rqs[0];
        #1;
        for (int p = 0; p < 2; p++) begin
            if (res[p].hit != expectHit) begin
                $display("ERROR %0t: port %0d vpn %h hit %b, expected %b", $time, p, vpn,
                         res[p].hit, expectHit);
                errors++;
            end
        end
        @(posedge clk);
        #1;
        rqs[0].valid = 1'b0;
        rqs[1].valid = 1'b0;
    endtask

    task automatic checkOneWalk(input logic [19:0] vpns [$]);
        foreach (vpns[i]) begin
            if (!walkCount.exists(vpns[i]) || walkCount[vpns[i]] != 1) begin
                $display("ERROR %0t: vpn %h walked %0d times, expected once", $time, vpns[i],
                         walkCount.exists(vpns[i]) ? walkCount[vpns[i]] : 0);
                errors++;
            end
        end
    endtask

    task automatic pulseClear();
        clear = 1'b1;
        @(posedge clk);
        #1;
        clear = 1'b0;
    endtask

    task automatic endTest(input string name);
        $display("Test %0d %s: %s", testNum, name, (errors == testErrors) ? "ok" : "errors");
        testNum++;
        testErrors = errors;
    endtask

    initial begin
        logic [19:0] list [$];
        logic [19:0] pool [$];
        logic [19:0] v;
        clk        = 1'b0;
        reset      = 1'b1;
        clear      = 1'b0;
        rqs[0]     = '0;
        rqs[1]     = '0;
        errors     = 0;
        testErrors = 0;
        testNum    = 1;
        memReads   = 0;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;

        findVpn(Page4k, v);
        list = '{v};
        probeHit(v, 1'b0);
        runSet(list, 200);
        checkOneWalk(list);
        endTest("4 KiB page");

        list.delete();
        for (int i = 0; i < 3; i++) begin
            findVpn((i == 2) ? Misalign : Super, v);
            list.push_back(v);
        end
        runSet(list, 400);
        endTest("superpages");

        list.delete();
        for (int k = NoWrite; k <= HighPpn; k++) begin
            findVpn(k, v);
            list.push_back(v);
        end
        runSet(list, 400);
        probeHit(list[0], 1'b1);  // Cached page without w on both ports.
        endTest("permissions and faults");

        pulseClear();
        list.delete();
        for (int i = 0; i < 4; i++) begin
            findVpn(Page4k, v);
            list.push_back(v);
        end
        runSet(list, 600);
        checkOneWalk(list);
        endTest("no duplicate walks");

        pulseClear();
        list.delete();
        for (int i = 0; i < 9; i++) begin
            findVpn(i % 6, v);
            list.push_back(v);
        end
        runSet(list, 3000);
        endTest("back-pressure");

        findVpn(Page4k, v);
        list = '{v};
        runSet(list, 200);
        pulseClear();
        probeHit(v, 1'b0);
        runSet(list, 200);
        checkOneWalk(list);
        for (int i = 0; i < 20; i++) begin
            findVpn((i < 14) ? i % 2 : $random(seed) & 7, v);  // Kinds above 5 give high ppns.
            pool.push_back(v);
        end
        for (int round = 0; round < 12; round++) begin
            list.delete();
            for (int i = 0; i < 5; i++) begin
                list.push_back(pool[($random(seed) & 32'h7fff_ffff) % pool.size()]);
            end
            runSet(list, 1500);
        end
        endTest("clear and replacement");

        $display("%0d tests, %0d errors", testNum - 1, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: dv/pageTableMem.sv
`timescale 1ns/1ps

module pageTableMem #(
    parameter int Seed = 0
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        memReq,
    input  logic [33:0] memAddr,
    output logic        memValid,
    output logic [31:0] memData
);

    logic [31:0] words [4096];  // Pages 0 to 3, root at page 1.
    logic [11:0] wordIdx;
    logic [2:0]  delay;
    logic        pending;
    int          seed;

    // Entry in Sv32 layout {ppn, rsvd, d, a, g, u, x, w, r, v}.
    function automatic logic [31:0] makePte(int sel, int r0, int r1);
        logic [21:0] ppn;
        logic [2:0]  rwx;
        ppn = r0[21:0];
        if (r1[3:2] != 2'b00) begin
            ppn[21:20] = 2'b00;  // Most pages fit in 20 bits.
        end
        rwx = (r1[6:4] == 3'b000) ? 3'b001 : r1[6:4];
        case (sel)
            0: return {ppn, 2'b00, r1[11:8], r1[6:4], 1'b0};
            1, 2, 3: return {22'(2 + r1[0]), 10'h001};  // Pointer to page 2 or 3.
            4, 5: return {ppn[21:10], 10'h000, 6'h00, rwx, 1'b1};
            default: return {ppn, 6'h00, rwx, 1'b1};
        endcase
    endfunction

    initial begin
        int sel;
        int r0;
        int r1;
        seed     = Seed;
        memValid = 1'b0;
        memData  = '0;
        for (int i = 0; i < 4096; i++) begin
            sel      = $random(seed) & 7;
            r0       = $random(seed);
            r1       = $random(seed);
            words[i] = makePte(sel, r0, r1);
        end
    end

    // One read in flight, answered 1 to 4 cycles after the strobe.
    always @(posedge clk) begin
        memValid <= 1'b0;
        if (reset) begin
            pending <= 1'b0;
        end else if (memReq) begin
            pending <= 1'b1;
            wordIdx <= memAddr[13:2];
            delay   <= 3'(1 + ($random(seed) & 3));
        end else if (pending) begin
            delay <= delay - 1'b1;
            if (delay == 3'd1) begin
                memValid <= 1'b1;
                memData  <= words[wordIdx];
                pending  <= 1'b0;
            end
        end
    end

endmodule

// File: logic/missQueue.sv
`timescale 1ns/1ps

module missQueue #(
    parameter int QueueDepth = 4
) (
    input  logic           clk,
    input  logic           reset,
    input  mmuPkg::MissReq miss [2],
    input  mmuPkg::WalkRes walkRes,
    output mmuPkg::MissReq head
);

    localparam int PtrBits = $clog2(QueueDepth);

    logic [19:0]           slotVpn [QueueDepth];
    logic [QueueDepth-1:0] slotValid;
    logic [PtrBits-1:0]    rdPtr;
    logic [PtrBits-1:0]    wrPtr;
    logic [PtrBits-1:0]    slot1;
    logic [1:0]            stored;
    logic                  push0;
    logic                  push1;

    // Compare against every slot, head included.
    always_comb begin
        stored = 2'b00;
        for (int p = 0; p < 2; p++) begin
            for (int k = 0; k < QueueDepth; k++) begin
                if (slotValid[k] && slotVpn[k] == miss[p].vpn) begin
                    stored[p] = 1'b1;
                end
            end
        end
    end

    assign push0 = miss[0].valid && !stored[0] && !slotValid[wrPtr];
    assign slot1 = wrPtr + PtrBits'(push0);
    // Port 1 yields to port 0 on the same page.
    assign push1 = miss[1].valid && !stored[1] && !slotValid[slot1]
                   && !(miss[0].valid && miss[0].vpn == miss[1].vpn);

    always_ff @(posedge clk) begin
        if (push0) begin
            slotVpn[wrPtr] <= miss[0].vpn;
        end
        if (push1) begin
            slotVpn[slot1] <= miss[1].vpn;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            slotValid <= '0;
            rdPtr     <= '0;
            wrPtr     <= '0;
        end else begin
            if (walkRes.valid && slotValid[rdPtr]) begin
                slotValid[rdPtr] <= 1'b0;  // Walk done, free head.
                rdPtr            <= rdPtr + 1'b1;
            end
            if (push0) begin
                slotValid[wrPtr] <= 1'b1;
            end
            if (push1) begin
                slotValid[slot1] <= 1'b1;
            end
            wrPtr <= wrPtr + PtrBits'(push0) + PtrBits'(push1);
        end
    end

    assign head.valid = slotValid[rdPtr];
    assign head.vpn   = slotVpn[rdPtr];

endmodule

// File: logic/mmuTop.sv
`timescale 1ns/1ps

module mmuTop #(
    parameter int TlbSize    = 8,
    parameter int TlbAssoc   = 4,
    parameter int QueueDepth = 4
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            clear,
    input  mmuPkg::TransReq rqs [2],
    output mmuPkg::TransRes res [2],
    input  logic [21:0]     rootPpn,
    output logic            memReq,
    output logic [33:0]     memAddr,
    input  logic            memValid,
    input  logic [31:0]     memData,
    output mmuPkg::WalkRes  walkOut
);

    mmuPkg::MissReq miss [2];
    mmuPkg::MissReq head;
    mmuPkg::WalkRes walkRes;

    tlb #(
        .TlbSize (TlbSize),
        .TlbAssoc(TlbAssoc)
    ) i_tlb (
        .clk    (clk),
        .reset  (reset),
        .clear  (clear),
        .walkRes(walkRes),
        .rqs    (rqs),
        .res    (res),
        .miss   (miss)
    );

    missQueue #(
        .QueueDepth(QueueDepth)
    ) i_missQueue (
        .clk    (clk),
        .reset  (reset),
        .miss   (miss),
        .walkRes(walkRes),
        .head   (head)
    );

    pageWalker i_pageWalker (
        .clk     (clk),
        .reset   (reset),
        .head    (head),
        .rootPpn (rootPpn),
        .memReq  (memReq),
        .memAddr (memAddr),
        .memValid(memValid),
        .memData (memData),
        .walkRes (walkRes)
    );

    assign walkOut = walkRes;

endmodule

// File: mmuTop.f
common/mmuPkg.sv
tlb/tlb.sv
logic/missQueue.sv
pageWalker/pageWalker.sv
logic/mmuTop.sv
dv/pageTableMem.sv
dv/mmuTb.sv

// File: pageWalker/pageWalker.sv
`timescale 1ns/1ps

module pageWalker (
    input  logic           clk,
    input  logic           reset,
    input  mmuPkg::MissReq head,
    input  logic [21:0]    rootPpn,
    output logic           memReq,
    output logic [33:0]    memAddr,
    input  logic           memValid,
    input  logic [31:0]    memData,
    output mmuPkg::WalkRes walkRes
);

    mmuPkg::WalkState state;
    mmuPkg::Pte       pte;

    logic [19:0] vpn;
    logic [21:0] tablePpn;  // Second level table base.
    logic [21:0] leafPpn;
    logic [2:0]  leafRwx;
    logic        leafSuper;
    logic        fault;
    logic        isLeaf;
    logic        badPerm;

    assign pte     = mmuPkg::Pte'(memData);
    assign isLeaf  = pte.r || pte.w || pte.x;
    assign badPerm = !pte.v || (pte.w && !pte.r);  // Invalid or write-only.

    ////////////////////////////////////////////////////////////////////
    // Memory port
    ////////////////////////////////////////////////////////////////////

    assign memReq = state == mmuPkg::ReqL1 || state == mmuPkg::ReqL0;

    always_comb begin
        if (state == mmuPkg::ReqL0 || state == mmuPkg::WaitL0) begin
            memAddr = {tablePpn, vpn[9:0], 2'b00};
        end else begin
            memAddr = {rootPpn, vpn[19:10], 2'b00};
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Walk FSM
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= mmuPkg::Idle;
        end else begin
            case (state)
                mmuPkg::Idle: begin
                    if (head.valid) begin
                        vpn       <= head.vpn;
                        fault     <= 1'b0;
                        leafSuper <= 1'b0;
                        state     <= mmuPkg::ReqL1;
                    end
                end
                mmuPkg::ReqL1: begin
                    state <= mmuPkg::WaitL1;
                end
                mmuPkg::WaitL1: begin
                    if (memValid) begin
                        if (badPerm) begin
                            fault <= 1'b1;
                            state <= mmuPkg::Done;
                        end else if (isLeaf) begin
                            leafPpn   <= pte.ppn;
                            leafRwx   <= {pte.r, pte.w, pte.x};
                            leafSuper <= 1'b1;
                            fault     <= pte.ppn[9:0] != 10'd0;  // Misaligned superpage.
                            state     <= mmuPkg::Done;
                        end else begin
                            tablePpn <= pte.ppn;
                            state    <= mmuPkg::ReqL0;
                        end
                    end
                end
                mmuPkg::ReqL0: begin
                    state <= mmuPkg::WaitL0;
                end
                mmuPkg::WaitL0: begin
                    if (memValid) begin
                        // Pointer at the last level is a fault too.
                        leafPpn   <= pte.ppn;
                        leafRwx   <= {pte.r, pte.w, pte.x};
                        leafSuper <= 1'b0;
                        fault     <= badPerm || !isLeaf;
                        state     <= mmuPkg::Done;
                    end
                end
                mmuPkg::Done: begin
                    state <= mmuPkg::Idle;
                end
                default: begin
                    state <= mmuPkg::Idle;
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Result
    ////////////////////////////////////////////////////////////////////

    assign walkRes.valid     = state == mmuPkg::Done;
    assign walkRes.vpn       = vpn;
    assign walkRes.ppn       = leafPpn;
    assign walkRes.isSuper   = leafSuper;
    assign walkRes.rwx       = leafRwx;
    assign walkRes.pageFault = fault;

endmodule

// File: tlb/tlb.sv
`timescale 1ns/1ps

module tlb #(
    parameter int TlbSize  = 8,
    parameter int TlbAssoc = 4
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            clear,
    input  mmuPkg::WalkRes  walkRes,
    input  mmuPkg::TransReq rqs [2],
    output mmuPkg::TransRes res [2],
    output mmuPkg::MissReq  miss [2]
);

    localparam int NumSets = TlbSize / TlbAssoc;
    localparam int IdxBits = $clog2(NumSets);
    localparam int WayBits = $clog2(TlbAssoc);
    localparam int TagBits = 20 - IdxBits;

    typedef struct packed {
        logic [TagBits-1:0] tag;
        logic [19:0]        ppn;
        logic               isSuper;
        logic [1:0]         perms;  // {r, w}, zero is invalid.
    } TlbEntry;

    TlbEntry            entries  [NumSets][TlbAssoc];
    logic [WayBits-1:0] counters [NumSets];
    logic [NumSets-1:0] advance;

    logic               fillEn;
    logic [IdxBits-1:0] fillIdx;
    logic [WayBits-1:0] fillWay;

    ////////////////////////////////////////////////////////////////////
    // Lookup
    ////////////////////////////////////////////////////////////////////

    always_comb begin
        logic [IdxBits-1:0] idx;
        TlbEntry            e;
        logic               match;

        advance = '0;
        for (int p = 0; p < 2; p++) begin
            idx    = rqs[p].vpn[IdxBits-1:0];
            res[p] = '0;
            for (int w = 0; w < TlbAssoc; w++) begin
                e = entries[idx][w];
                if (e.isSuper) begin
                    // Superpage covers vpn[9:0].
                    match = e.tag[TagBits-1:10-IdxBits] == rqs[p].vpn[19:10];
                end else begin
                    match = e.tag == rqs[p].vpn[19:IdxBits];
                end
                if (rqs[p].valid && e.perms != 2'b00 && match) begin
                    res[p].hit   = 1'b1;
                    res[p].fault = !e.perms[p];  // Port 0 needs w, port 1 needs r.
                    res[p].ppn   = e.isSuper ? {e.ppn[19:10], rqs[p].vpn[9:0]} : e.ppn;
                    if (counters[idx] == WayBits'(w)) begin
                        advance[idx] = 1'b1;
                    end
                end
            end
            miss[p].valid = rqs[p].valid && !res[p].hit;
            miss[p].vpn   = rqs[p].vpn;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Fill and replacement
    ////////////////////////////////////////////////////////////////////

    // Results above 20 ppn bits do not fit the entry and are never cached.
    assign fillEn  = walkRes.valid && !walkRes.pageFault && walkRes.ppn[21:20] == 2'b00;
    assign fillIdx = walkRes.vpn[IdxBits-1:0];
    assign fillWay = counters[fillIdx];

    always_ff @(posedge clk) begin
        if (reset || clear) begin
            for (int s = 0; s < NumSets; s++) begin
                for (int w = 0; w < TlbAssoc; w++) begin
                    entries[s][w].perms <= 2'b00;
                end
            end
        end else if (fillEn) begin
            entries[fillIdx][fillWay].tag     <= walkRes.vpn[19:IdxBits];
            entries[fillIdx][fillWay].ppn     <= walkRes.ppn[19:0];
            entries[fillIdx][fillWay].isSuper <= walkRes.isSuper;
            entries[fillIdx][fillWay].perms   <= walkRes.rwx[2:1];
        end
    end

    // Round robin per set, moved on by hits to the pointed way.
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int s = 0; s < NumSets; s++) begin
                counters[s] <= '0;
            end
        end else begin
            for (int s = 0; s < NumSets; s++) begin
                if (advance[s]) begin
                    counters[s] <= counters[s] + 1'b1;
                end
            end
        end
    end

endmodule
